/* all.f */
x86_regs_pkg.sv
exec_ops_pkg.sv
op_decoder.sv
regfile.sv
alu_writeback.sv
exec_core.sv
exec_checker.sv
tb_exec_core.sv

/* alu_writeback.sv */
`default_nettype none

module alu_writeback (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    stage_valid,
  input  exec_ops_pkg::op_code_t  stage_op,
  input  x86_regs_pkg::word_t     stage_imm,
  input  logic                    stage_word,
  input  x86_regs_pkg::reg_addr_t stage_dst,
  input  x86_regs_pkg::word_t     a,
  input  x86_regs_pkg::word_t     b,
  input  x86_regs_pkg::flags_t    flags,
  input  x86_regs_pkg::word_t     ip,
  output x86_regs_pkg::dword_t    d,
  output x86_regs_pkg::reg_addr_t addr_d,
  output logic                    wr,
  output logic                    wrfl,
  output logic                    wrhi,
  output logic                    wr_ip0,
  output logic                    word_op,
  output x86_regs_pkg::flags_t    iflags,
  output logic                    done,
  output x86_regs_pkg::word_t     result
);

  import x86_regs_pkg::*;
  import exec_ops_pkg::*;

  logic        is_sub;
  logic        is_incdec;
  logic        is_logic;
  word_t       op2;
  logic [16:0] sum_w;
  logic [8:0]  sum_b;
  dword_t      product;
  word_t       res;
  word_t       res_out;
  logic        msb_a;
  logic        msb_2;
  logic        msb_r;
  logic        carry;
  flags_t      new_flags;

  // Operation classes.
  assign is_sub    = (stage_op == OP_SUB) || (stage_op == OP_DEC);
  assign is_incdec = (stage_op == OP_INC) || (stage_op == OP_DEC);
  assign is_logic  = (stage_op == OP_AND) || (stage_op == OP_OR) || (stage_op == OP_XOR);

  // INC and DEC use a constant one as the second operand.
  assign op2 = is_incdec ? 16'd1 : b;

  // Adder at both widths; bit 16 or bit 8 is the carry or borrow.
  assign sum_w = is_sub ? ({1'b0, a} - {1'b0, op2}) : ({1'b0, a} + {1'b0, op2});
  assign sum_b = is_sub ? ({1'b0, a[7:0]} - {1'b0, op2[7:0]})
                        : ({1'b0, a[7:0]} + {1'b0, op2[7:0]});

  // Unsigned 16x16 multiply.
  assign product = dword_t'(a) * dword_t'(b);

  always_comb begin
    case (stage_op)
      OP_MOV:    res = b;
      OP_MOVI:   res = stage_imm;
      OP_AND:    res = a & b;
      OP_OR:     res = a | b;
      OP_XOR:    res = a ^ b;
      OP_MUL:    res = product[15:0];
      OP_SAVEIP: res = ip;
      // ADD, SUB, INC, DEC.
      default:   res = sum_w[15:0];
    endcase
  end

  // Byte results are reported zero-extended.
  assign res_out = stage_word ? res : {8'h00, res[7:0]};

  // Sign bits and carry at the operation width.
  assign msb_a = stage_word ? a[15] : a[7];
  assign msb_2 = stage_word ? op2[15] : op2[7];
  assign msb_r = stage_word ? res[15] : res[7];
  assign carry = stage_word ? sum_w[16] : sum_b[8];

  always_comb begin
    // TF, IF and DF pass through untouched.
    new_flags = flags;
    new_flags[FLAG_ZF] = stage_word ? (res == '0) : (res[7:0] == '0);
    new_flags[FLAG_SF] = msb_r;
    // Parity is even parity of the low byte only.
    new_flags[FLAG_PF] = ~^res[7:0];
    if (is_logic) begin
      new_flags[FLAG_CF] = 1'b0;
      new_flags[FLAG_OF] = 1'b0;
      new_flags[FLAG_AF] = 1'b0;
    end else begin
      // Carry out of bit 3.
      new_flags[FLAG_AF] = a[4] ^ op2[4] ^ res[4];
      // Overflow when the sign of the result is impossible.
      if (is_sub) begin
        new_flags[FLAG_OF] = (msb_a != msb_2) && (msb_r != msb_a);
      end else begin
        new_flags[FLAG_OF] = (msb_a == msb_2) && (msb_r != msb_a);
      end
      // INC and DEC keep the previous carry.
      if (!is_incdec) begin
        new_flags[FLAG_CF] = carry;
      end
    end
    // MUL only reports whether DX holds significant bits.
    if (stage_op == OP_MUL) begin
      new_flags = flags;
      new_flags[FLAG_CF] = |product[31:16];
      new_flags[FLAG_OF] = |product[31:16];
    end
  end

  // All write controls are driven in the stage cycle.
  assign wr     = stage_valid && (stage_op != OP_SAVEIP);
  assign wrfl   = stage_valid && (stage_op != OP_MOV) && (stage_op != OP_MOVI)
                  && (stage_op != OP_SAVEIP);
  assign wrhi   = stage_valid && (stage_op == OP_MUL);
  assign wr_ip0 = stage_valid && (stage_op == OP_SAVEIP);

  // MUL writes AX and every other operation writes the named destination.
  assign addr_d  = (stage_op == OP_MUL) ? REG_AX : stage_dst;
  assign word_op = stage_word;
  assign iflags  = new_flags;
  assign d       = (stage_op == OP_MUL) ? product : {16'h0000, res};

  // Completion pulses one cycle after the stage.
  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
    end else begin
      done <= stage_valid;
    end
  end

  // Result holds until the next operation completes.
  always_ff @(posedge clk) begin
    if (stage_valid) begin
      result <= res_out;
    end
  end

  // Only the defined operation codes may reach the stage.
  stage_op_defined: assert property (
    @(posedge clk) disable iff (rst)
    stage_valid |-> (stage_op <= OP_SAVEIP)
  );

endmodule

`default_nettype wire

/* exec_checker.sv */
`default_nettype none

module exec_checker #(
  parameter x86_regs_pkg::word_t CS_EXP = 16'hF000,
  parameter x86_regs_pkg::word_t IP_EXP = 16'hFFF0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 exp_valid,
  input  x86_regs_pkg::word_t  exp_result,
  input  x86_regs_pkg::flags_t exp_flags,
  input  x86_regs_pkg::word_t  exp_peek,
  input  logic                 exp_cxz,
  input  logic                 done,
  input  x86_regs_pkg::word_t  result,
  input  x86_regs_pkg::flags_t flags,
  input  logic                 cx_zero,
  input  x86_regs_pkg::word_t  cs,
  input  x86_regs_pkg::word_t  ip,
  input  x86_regs_pkg::word_t  peek_data,
  output int                   pass_count,
  output int                   fail_count,
  output int                   pending
);

  timeunit 1ns;
  timeprecision 100ps;

  import x86_regs_pkg::*;

  // Expected records in strobe order.
  word_t  q_result[$];
  flags_t q_flags[$];
  word_t  q_peek[$];
  logic   q_cxz[$];
  int     q_due[$];
  int     q_id[$];

  // Rising edges since reset, and the test number of the next strobe.
  int     cyc;
  int     next_id;

  // Compare one value, report a mismatch, return the error count.
  function automatic int check_value(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      return 1;
    end
    return 0;
  endfunction

  task automatic drop_front();
    void'(q_result.pop_front());
    void'(q_flags.pop_front());
    void'(q_peek.pop_front());
    void'(q_cxz.pop_front());
    void'(q_due.pop_front());
    void'(q_id.pop_front());
  endtask

  always @(posedge clk) begin
    int errs;
    if (rst) begin
      q_result.delete();
      q_flags.delete();
      q_peek.delete();
      q_cxz.delete();
      q_due.delete();
      q_id.delete();
      cyc        = 0;
      next_id    = 1;
      pass_count = 0;
      fail_count = 0;
      pending    = 0;
    end else begin
      if (done) begin
        if (q_due.size() == 0) begin
          $display("done came at %0t with no operation pending", $time);
          fail_count++;
        end else begin
          errs = 0;
          errs += check_value("result", result, q_result[0]);
          errs += check_value("flags", word_t'(flags), word_t'(q_flags[0]));
          errs += check_value("cx_zero", word_t'(cx_zero), word_t'(q_cxz[0]));
          errs += check_value("peek_data", peek_data, q_peek[0]);
          // No operation in the vectors moves CS or IP away from their reset values.
          errs += check_value("cs", cs, CS_EXP);
          errs += check_value("ip", ip, IP_EXP);
          // Strobe edge plus two.
          if (q_due[0] != cyc) begin
            $display("test %0d: done came at edge %0d instead of edge %0d",
                     q_id[0], cyc, q_due[0]);
            errs++;
          end
          if (errs == 0) begin
            $display("test %0d ok", q_id[0]);
            pass_count++;
          end else begin
            $display("test %0d failed with %0d errors", q_id[0], errs);
            fail_count++;
          end
          drop_front();
        end
      end else if ((q_due.size() > 0) && (q_due[0] < cyc)) begin
        $display("test %0d: done never came", q_id[0]);
        fail_count++;
        drop_front();
      end
      if (exp_valid) begin
        q_result.push_back(exp_result);
        q_flags.push_back(exp_flags);
        q_peek.push_back(exp_peek);
        q_cxz.push_back(exp_cxz);
        q_due.push_back(cyc + 2);
        q_id.push_back(next_id);
        next_id++;
      end
      cyc++;
      pending = q_due.size();
    end
  end

endmodule

`default_nettype wire

/* exec_core.sv */
`default_nettype none

module exec_core #(
  parameter x86_regs_pkg::word_t CS_RESET = 16'hF000,
  parameter x86_regs_pkg::word_t IP_RESET = 16'hFFF0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    op_valid,
  input  exec_ops_pkg::op_code_t  op_code,
  input  x86_regs_pkg::reg_addr_t dst,
  input  x86_regs_pkg::reg_addr_t src,
  input  x86_regs_pkg::word_t     imm,
  input  logic                    word_op,
  input  x86_regs_pkg::reg_addr_t peek_addr,
  output logic                    done,
  output x86_regs_pkg::word_t     result,
  output x86_regs_pkg::flags_t    flags,
  output logic                    cx_zero,
  output x86_regs_pkg::word_t     ip,
  output x86_regs_pkg::word_t     cs,
  output x86_regs_pkg::word_t     peek_data
);

  import x86_regs_pkg::*;
  import exec_ops_pkg::*;

  // Decoder to register file.
  reg_addr_t addr_a;
  reg_addr_t addr_b;
  logic      a_byte;
  logic      b_byte;

  // Decoder to writeback.
  logic      stage_valid;
  op_code_t  stage_op;
  word_t     stage_imm;
  logic      stage_word;
  reg_addr_t stage_dst;

  // Register file read data.
  word_t     a;
  word_t     b;

  // Writeback to register file.
  dword_t    d;
  reg_addr_t addr_d;
  logic      wr;
  logic      wrfl;
  logic      wrhi;
  logic      wr_ip0;
  logic      wb_word_op;
  flags_t    iflags;

  op_decoder dec_i (
    .clk        (clk),
    .rst        (rst),
    .op_valid   (op_valid),
    .op_code    (op_code),
    .dst        (dst),
    .src        (src),
    .imm        (imm),
    .word_op    (word_op),
    .addr_a     (addr_a),
    .addr_b     (addr_b),
    .stage_dst  (stage_dst),
    .a_byte     (a_byte),
    .b_byte     (b_byte),
    .stage_valid(stage_valid),
    .stage_op   (stage_op),
    .stage_imm  (stage_imm),
    .stage_word (stage_word)
  );

  // Port c is the word-only peek port.
  regfile #(
    .CS_RESET(CS_RESET),
    .IP_RESET(IP_RESET)
  ) regs_i (
    .clk    (clk),
    .rst    (rst),
    .addr_a (addr_a),
    .addr_b (addr_b),
    .addr_c (peek_addr),
    .addr_d (addr_d),
    .a_byte (a_byte),
    .b_byte (b_byte),
    .c_byte (1'b0),
    .d      (d),
    .wr     (wr),
    .wrfl   (wrfl),
    .wrhi   (wrhi),
    .wr_ip0 (wr_ip0),
    .word_op(wb_word_op),
    .iflags (iflags),
    .a      (a),
    .b      (b),
    .c      (peek_data),
    .cs     (cs),
    .ip     (ip),
    .flags  (flags),
    .cx_zero(cx_zero)
  );

  alu_writeback wb_i (
    .clk        (clk),
    .rst        (rst),
    .stage_valid(stage_valid),
    .stage_op   (stage_op),
    .stage_imm  (stage_imm),
    .stage_word (stage_word),
    .stage_dst  (stage_dst),
    .a          (a),
    .b          (b),
    .flags      (flags),
    .ip         (ip),
    .d          (d),
    .addr_d     (addr_d),
    .wr         (wr),
    .wrfl       (wrfl),
    .wrhi       (wrhi),
    .wr_ip0     (wr_ip0),
    .word_op    (wb_word_op),
    .iflags     (iflags),
    .done       (done),
    .result     (result)
  );

endmodule

`default_nettype wire

/* exec_ops_pkg.sv */
`default_nettype none

package exec_ops_pkg;

  // Width of the operation field.
  localparam int OP_WIDTH = 4;

  // Operation code as carried from the decoder to the writeback.
  typedef logic [OP_WIDTH-1:0] op_code_t;

  // Copy the source register into the destination.
  localparam op_code_t OP_MOV = 4'd0;

  // Load the immediate into the destination.
  localparam op_code_t OP_MOVI = 4'd1;

  // Two-operand arithmetic, destination is also the first operand.
  localparam op_code_t OP_ADD = 4'd2;
  localparam op_code_t OP_SUB = 4'd3;

  // Bitwise logic, CF and OF cleared.
  localparam op_code_t OP_AND = 4'd4;
  localparam op_code_t OP_OR = 4'd5;
  localparam op_code_t OP_XOR = 4'd6;

  // Increment and decrement by one, CF left alone.
  localparam op_code_t OP_INC = 4'd7;
  localparam op_code_t OP_DEC = 4'd8;

  // Unsigned word multiply of AX by the source into DX:AX.
  localparam op_code_t OP_MUL = 4'd9;

  // Copy IP into the scratch register 14.
  localparam op_code_t OP_SAVEIP = 4'd10;

  // Codes 11 to 15 are unused.

endpackage

`default_nettype wire

/* golden_vectors.txt */
# op dst src imm word gap | result flags peek_reg peek_value cx_zero (all hex)
# gap counts idle cycles after the strobe, 0 sends the next operation on the next cycle
0 0 0 0000 1 3 0000 000 1 0000 1
0 2 3 0000 1 3 0000 000 4 0000 1
0 9 9 0000 1 3 f000 000 f fff0 1
0 c d 0000 1 3 0000 000 e 0000 1
0 8 b 0000 1 3 0000 000 a 0000 1
1 0 0 7fff 1 3 7fff 000 0 7fff 1
1 3 0 0001 1 3 0001 000 3 0001 1
2 0 3 0000 1 3 8000 116 0 8000 1
3 0 3 0000 1 3 7fff 106 0 7fff 1
1 1 0 0001 1 3 0001 106 1 0001 0
8 1 0 0000 1 3 0000 00a 1 0000 1
3 3 0 0000 1 3 8002 015 3 8002 1
7 3 0 0000 1 3 8003 013 3 8003 1
4 3 0 0000 1 3 0003 002 0 7fff 1
2 0 0 0000 1 3 fffe 114 0 fffe 1
6 3 3 0000 1 3 0000 00a 3 0000 1
5 3 0 0000 1 3 fffe 010 3 fffe 1
1 0 0 1234 1 3 1234 010 0 1234 1
1 4 0 0085 0 3 0085 010 0 8534 1
0 1 4 0000 0 3 0085 010 1 0085 0
2 0 4 0000 0 3 00b9 010 0 85b9 0
1 7 0 0011 0 3 0011 010 3 11fe 0
7 7 0 0000 0 3 0012 002 3 12fe 0
1 0 0 0100 1 3 0100 002 0 0100 0
1 1 0 0300 1 3 0300 002 1 0300 0
9 0 1 0000 1 3 0000 103 2 0003 0
1 0 0 0010 1 3 0010 103 0 0010 0
1 3 0 0020 1 3 0020 103 3 0020 0
9 0 3 0000 1 3 0200 002 2 0000 0
1 1 0 0002 1 0 0002 002 1 0002 0
8 1 0 0000 1 0 0001 000 1 0001 1
8 1 0 0000 1 0 0000 00a 1 0000 1
a 0 0 0000 1 3 fff0 00a e fff0 1

/* op_decoder.sv */
`default_nettype none

module op_decoder (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    op_valid,
  input  exec_ops_pkg::op_code_t  op_code,
  input  x86_regs_pkg::reg_addr_t dst,
  input  x86_regs_pkg::reg_addr_t src,
  input  x86_regs_pkg::word_t     imm,
  input  logic                    word_op,
  output x86_regs_pkg::reg_addr_t addr_a,
  output x86_regs_pkg::reg_addr_t addr_b,
  output x86_regs_pkg::reg_addr_t stage_dst,
  output logic                    a_byte,
  output logic                    b_byte,
  output logic                    stage_valid,
  output exec_ops_pkg::op_code_t  stage_op,
  output x86_regs_pkg::word_t     stage_imm,
  output logic                    stage_word
);

  import x86_regs_pkg::*;
  import exec_ops_pkg::*;

  // Latched source field, only used to form addr_b.
  reg_addr_t src_q;

  // One stage of valid, cleared on reset.
  always_ff @(posedge clk) begin
    if (rst) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= op_valid;
    end
  end

  // Operation fields, loaded on each strobe.
  always_ff @(posedge clk) begin
    if (op_valid) begin
      stage_op  <= op_code;
      stage_dst <= dst;
      src_q     <= src;
      stage_imm <= imm;
      // MUL and SAVEIP only exist in word form.
      stage_word <= word_op || (op_code == OP_MUL) || (op_code == OP_SAVEIP);
    end
  end

  // Operand addresses for the register file read ports.
  always_comb begin
    // First operand is the destination.
    addr_a = stage_dst;
    // MUL always takes AX as the first operand.
    if (stage_op == OP_MUL) begin
      addr_a = REG_AX;
    end

    // Second operand is the source.
    addr_b = src_q;
    // No source for immediates or the IP copy.
    if ((stage_op == OP_MOVI) || (stage_op == OP_SAVEIP)) begin
      addr_b = REG_AX;
    end
  end

  // Byte lanes apply to general registers 0 to 7 only.
  assign a_byte = !stage_word && !addr_a[3];
  assign b_byte = !stage_word && !addr_b[3];

  // Byte operations are meant for AL..BH, never segment or scratch.
  a_byte_dst_general: assert property (
    @(posedge clk) disable iff (rst)
    stage_valid && !stage_word |-> !stage_dst[3]
  );

endmodule

`default_nettype wire

/* regfile.sv */
`default_nettype none

module regfile #(
  parameter x86_regs_pkg::word_t CS_RESET = 16'hF000,
  parameter x86_regs_pkg::word_t IP_RESET = 16'hFFF0
) (
  input  logic                    clk,
  input  logic                    rst,
  input  x86_regs_pkg::reg_addr_t addr_a,
  input  x86_regs_pkg::reg_addr_t addr_b,
  input  x86_regs_pkg::reg_addr_t addr_c,
  input  x86_regs_pkg::reg_addr_t addr_d,
  input  logic                    a_byte,
  input  logic                    b_byte,
  input  logic                    c_byte,
  input  x86_regs_pkg::dword_t    d,
  input  logic                    wr,
  input  logic                    wrfl,
  input  logic                    wrhi,
  input  logic                    wr_ip0,
  input  logic                    word_op,
  input  x86_regs_pkg::flags_t    iflags,
  output x86_regs_pkg::word_t     a,
  output x86_regs_pkg::word_t     b,
  output x86_regs_pkg::word_t     c,
  output x86_regs_pkg::word_t     cs,
  output x86_regs_pkg::word_t     ip,
  output x86_regs_pkg::flags_t    flags,
  output logic                    cx_zero
);

  import x86_regs_pkg::*;

  // CH alias of CX in byte mode.
  localparam reg_addr_t CH_ADDR = REG_CX | 4'd4;

  // 0-7 general, 8-11 segment, 12-14 scratch, 15 IP.
  word_t r [16];

  // CX as it will be after the current write.
  word_t cx_next;

  // Read one port, with the 8086 byte aliasing on addresses 0 to 7.
  function automatic word_t read_port(input reg_addr_t addr, input logic byte_sel);
    byte_t lane;
    // Addresses 4-7 pick the high byte of registers 0-3.
    lane = addr[2] ? r[{2'b00, addr[1:0]}][15:8] : r[addr][7:0];
    if (byte_sel && !addr[3]) begin
      return {{8{lane[7]}}, lane};
    end
    return r[addr];
  endfunction

  // Three combinational read ports.
  always_comb begin
    a = read_port(addr_a, a_byte);
    b = read_port(addr_b, b_byte);
    c = read_port(addr_c, c_byte);
  end

  assign cs = r[REG_CS];
  assign ip = r[REG_IP];

  // Bypass the CX write, so a loop test sees the new count.
  always_comb begin
    cx_next = r[REG_CX];
    if (wr && (addr_d == REG_CX)) begin
      cx_next = word_op ? d[15:0] : {r[REG_CX][15:8], d[7:0]};
    end else if (wr && !word_op && (addr_d == CH_ADDR)) begin
      cx_next = {d[7:0], r[REG_CX][7:0]};
    end
  end

  assign cx_zero = (cx_next == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 16; i++) begin
        r[i] <= '0;
      end
      // Start at the reset vector F000:FFF0 by default.
      r[REG_CS] <= CS_RESET;
      r[REG_IP] <= IP_RESET;
      flags     <= '0;
    end else begin
      if (wr) begin
        if (word_op || (addr_d[3:2] == 2'b10)) begin
          // Word write, or byte into a segment register, sign-extended.
          r[addr_d] <= word_op ? d[15:0] : {{8{d[7]}}, d[7:0]};
        end else if (addr_d[3] == addr_d[2]) begin
          // Low byte: AL, CL, DL, BL, and the scratch registers.
          r[addr_d][7:0] <= d[7:0];
        end else begin
          // High byte: AH, CH, DH, BH.
          r[{2'b00, addr_d[1:0]}][15:8] <= d[7:0];
        end
      end
      if (wrfl) begin
        flags <= iflags;
      end
      // Upper half of a multiply product goes to DX.
      if (wrhi) begin
        r[REG_DX] <= d[31:16];
      end
      if (wr_ip0) begin
        r[REG_IP_SAVE] <= r[REG_IP];
      end
    end
  end

  // The DX half of a product only comes along with the AX half.
  wrhi_with_ax_write: assert property (
    @(posedge clk) disable iff (rst)
    wrhi |-> wr && (addr_d == REG_AX)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the exec_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f all.f --top-module tb_exec_core \
  -o sim_exec_core \
  && ./obj_dir/sim_exec_core > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* tb_exec_core.sv */
`default_nettype none

module tb_exec_core;

  timeunit 1ns;
  timeprecision 100ps;

  import x86_regs_pkg::*;
  import exec_ops_pkg::*;

  // Reset vector F000:FFF0.
  localparam word_t CS_INIT = 16'hF000;
  localparam word_t IP_INIT = 16'hFFF0;

  // DUT inputs.
  logic      clk = 1'b0;
  logic      rst;
  logic      op_valid;
  op_code_t  op_code;
  reg_addr_t dst;
  reg_addr_t src;
  word_t     imm;
  logic      word_op;
  reg_addr_t peek_addr;

  // DUT outputs.
  logic      done;
  word_t     result;
  flags_t    flags;
  logic      cx_zero;
  word_t     ip;
  word_t     cs;
  word_t     peek_data;

  // Expected record handed to the checker with each strobe.
  logic      exp_valid;
  word_t     exp_result;
  flags_t    exp_flags;
  word_t     exp_peek;
  logic      exp_cxz;

  int        pass_count;
  int        fail_count;
  int        pending;

  // Peek registers of operations still waiting for done.
  reg_addr_t peek_q[$];

  always #5 clk = ~clk;

  exec_core #(
    .CS_RESET(CS_INIT),
    .IP_RESET(IP_INIT)
  ) dut_i (
    .clk      (clk),
    .rst      (rst),
    .op_valid (op_valid),
    .op_code  (op_code),
    .dst      (dst),
    .src      (src),
    .imm      (imm),
    .word_op  (word_op),
    .peek_addr(peek_addr),
    .done     (done),
    .result   (result),
    .flags    (flags),
    .cx_zero  (cx_zero),
    .ip       (ip),
    .cs       (cs),
    .peek_data(peek_data)
  );

  exec_checker #(
    .CS_EXP(CS_INIT),
    .IP_EXP(IP_INIT)
  ) chk_i (
    .clk       (clk),
    .rst       (rst),
    .exp_valid (exp_valid),
    .exp_result(exp_result),
    .exp_flags (exp_flags),
    .exp_peek  (exp_peek),
    .exp_cxz   (exp_cxz),
    .done      (done),
    .result    (result),
    .flags     (flags),
    .cx_zero   (cx_zero),
    .cs        (cs),
    .ip        (ip),
    .peek_data (peek_data),
    .pass_count(pass_count),
    .fail_count(fail_count),
    .pending   (pending)
  );

  // Step to the falling edge and point the peek port at the completing operation.
  task automatic next_negedge();
    @(negedge clk);
    if (done && (peek_q.size() > 0)) begin
      peek_addr = peek_q.pop_front();
    end
  endtask

  initial begin
    int        fd;
    int        fields;
    int        total;
    int        gap;
    int        waited;
    string     line;
    op_code_t  f_op;
    reg_addr_t f_dst;
    reg_addr_t f_src;
    reg_addr_t f_peek;
    word_t     f_imm;
    word_t     f_res;
    word_t     f_pkv;
    flags_t    f_flags;
    logic      f_word;
    logic      f_cxz;
    rst        = 1'b1;
    op_valid   = 1'b0;
    op_code    = '0;
    dst        = '0;
    src        = '0;
    imm        = '0;
    word_op    = 1'b1;
    peek_addr  = '0;
    exp_valid  = 1'b0;
    exp_result = '0;
    exp_flags  = '0;
    exp_peek   = '0;
    exp_cxz    = 1'b0;
    total      = 0;
    fd = $fopen("golden_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open golden_vectors.txt");
      $display("tests failed");
      $finish;
    end else begin
      repeat (16) @(posedge clk);
      next_negedge();
      rst = 1'b0;
      next_negedge();
      while ($fgets(line, fd) != 0) begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f_op, f_dst, f_src,
                         f_imm, f_word, gap, f_res, f_flags, f_peek, f_pkv, f_cxz);
        // Comment lines and blank lines do not parse.
        if ((line.getc(0) != "#") && (fields == 11)) begin
          op_valid   = 1'b1;
          op_code    = f_op;
          dst        = f_dst;
          src        = f_src;
          imm        = f_imm;
          word_op    = f_word;
          exp_valid  = 1'b1;
          exp_result = f_res;
          exp_flags  = f_flags;
          exp_peek   = f_pkv;
          exp_cxz    = f_cxz;
          peek_q.push_back(f_peek);
          total++;
          next_negedge();
          op_valid  = 1'b0;
          exp_valid = 1'b0;
          for (int i = 0; i < gap; i++) begin
            next_negedge();
          end
        end
      end
      $fclose(fd);
      // Drain the operations still in flight.
      waited = 0;
      while ((pending != 0) && (waited < 50)) begin
        next_negedge();
        waited++;
      end
      if (pending != 0) begin
        $display("done never came for %0d pending operations", pending);
      end
      $display("%0d tests, %0d passed, %0d failed", total, pass_count, fail_count);
      if ((fail_count == 0) && (pending == 0) && (pass_count == total)) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

/* x86_regs_pkg.sv */
`default_nettype none

package x86_regs_pkg;

  // One 16-bit register value.
  typedef logic [15:0] word_t;

  // Double word, DX in the upper half and AX in the lower half.
  typedef logic [31:0] dword_t;

  // One byte lane of a general register.
  typedef logic [7:0] byte_t;

  // Register file address over sixteen entries.
  typedef logic [3:0] reg_addr_t;

  // Flags word, OF in the top bit and CF in bit 0.
  typedef logic [8:0] flags_t;

  // General registers in word mode.
  localparam reg_addr_t REG_AX = 4'd0;
  localparam reg_addr_t REG_CX = 4'd1;
  localparam reg_addr_t REG_DX = 4'd2;

  // Code segment, one of the four segment registers 8 to 11.
  localparam reg_addr_t REG_CS = 4'd9;

  // Scratch register that receives IP, and IP itself.
  localparam reg_addr_t REG_IP_SAVE = 4'd14;
  localparam reg_addr_t REG_IP = 4'd15;

  // Flag bit positions, 8086 order with the reserved bits squeezed out.
  localparam int FLAG_CF = 0;
  localparam int FLAG_PF = 1;
  localparam int FLAG_AF = 2;
  localparam int FLAG_ZF = 3;
  localparam int FLAG_SF = 4;
  localparam int FLAG_TF = 5;
  localparam int FLAG_IF = 6;
  localparam int FLAG_DF = 7;
  localparam int FLAG_OF = 8;

endpackage

`default_nettype wire
